//--- source/mailbox_pkg.sv
`default_nettype none

package mailbox_pkg;

	localparam int data_w        = 32;	// Bus and FIFO word width
	localparam int in_depth_log  = 3;	// Input FIFO holds 8 words
	localparam int out_depth_log = 2;	// Output FIFO holds 4 words
	localparam int addr_w        = 2;	// Word address width

	localparam logic [addr_w-1:0] addr_data   = 2'd0;	// Push input / pop output
	localparam logic [addr_w-1:0] addr_ctrl   = 2'd1;	// Opcode and overflow clear
	localparam logic [addr_w-1:0] addr_key    = 2'd2;	// Add key
	localparam logic [addr_w-1:0] addr_status = 2'd3;	// Read-only status

	localparam int ctrl_clr_ovf       = 31;	// Write 1 clears sticky overflow
	localparam int st_in_empty        = 0;
	localparam int st_in_full         = 1;
	localparam int st_out_empty       = 2;
	localparam int st_out_almost_full = 3;
	localparam int st_overflow        = 4;
	localparam int st_out_count_lo    = 8;	// Output level field, bits 10..8
	localparam int st_out_count_hi    = 10;

	typedef enum logic [1:0] {op_pass = 2'd0, op_invert, op_swap, op_add} op_e;

	typedef enum logic {st_idle = 1'b0, st_push = 1'b1} eng_state_e;

endpackage : mailbox_pkg

`default_nettype wire

//--- source/fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fifo #(
	parameter int BUF_WIDTH  = 3,	// Depth is 2**BUF_WIDTH
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [DATA_WIDTH-1:0] buf_in,	// Push data
	input  logic                  wr_en,
	input  logic                  rd_en,
	output logic [DATA_WIDTH-1:0] buf_out,	// Head word while popping
	output logic                  buf_empty,
	output logic                  buf_full,
	output logic                  buf_almost_full,
	output logic [BUF_WIDTH:0]    fifo_counter	// Occupancy, one extra bit for full
);

	logic [DATA_WIDTH-1:0] buf_mem [1 << BUF_WIDTH];	// Circular storage
	logic [BUF_WIDTH-1:0]  rd_ptr;
	logic [BUF_WIDTH-1:0]  wr_ptr;
	logic                  push;	// Accepted write
	logic                  pop;	// Accepted read

	assign push = wr_en && !buf_full;	// Full FIFO drops the push
	assign pop  = rd_en && !buf_empty;	// Empty FIFO ignores the pop

	always_comb begin
		buf_empty       = (fifo_counter == '0);
		buf_full        = fifo_counter[BUF_WIDTH];	// MSB set only at full depth
		buf_almost_full = buf_full || (&fifo_counter[BUF_WIDTH-1:0]);	// One slot left or none
	end

	always_comb begin
		if (pop)
			buf_out = buf_mem[rd_ptr];	// Combinational read at head
		else
			buf_out = '0;	// Zero when idle or empty
	end

	always_ff @(posedge clk) begin
		if (push)
			buf_mem[wr_ptr] <= buf_in;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			fifo_counter <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
			2'b10:   fifo_counter <= fifo_counter + 1'b1;
			2'b01:   fifo_counter <= fifo_counter - 1'b1;
			default: fifo_counter <= fifo_counter;	// Both or neither keeps level
			endcase
		end
	end

endmodule : fifo

`default_nettype wire

//--- source/wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_regs import mailbox_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [addr_w-1:0]      wb_adr,
	input  logic [data_w-1:0]      wb_wdata,
	output logic [data_w-1:0]      wb_rdata,
	output logic                   wb_ack,
	output logic                   in_wr,	// Push strobe to input FIFO
	output logic [data_w-1:0]      in_wdata,
	input  logic                   in_empty,
	input  logic                   in_full,
	output logic                   out_rd,	// Pop strobe to output FIFO
	input  logic [data_w-1:0]      out_rdata,
	input  logic                   out_empty,
	input  logic                   out_almost_full,
	input  logic [out_depth_log:0] out_count,
	output op_e                    opcode,
	output logic [data_w-1:0]      key
);

	logic              req;	// New cycle, ack not yet given
	logic              wr_req;
	logic              rd_req;
	logic              overflow;	// Sticky dropped-write flag
	logic [data_w-1:0] status_word;

	assign req    = wb_cyc && wb_stb && !wb_ack;
	assign wr_req = req && wb_we;
	assign rd_req = req && !wb_we;

	assign in_wr    = wr_req && (wb_adr == addr_data) && !in_full;	// Full drops the word
	assign in_wdata = wb_wdata;
	assign out_rd   = rd_req && (wb_adr == addr_data);	// Pop in the acking cycle

	always_comb begin
		status_word                                     = '0;	// Unused bits read zero
		status_word[st_in_empty]                        = in_empty;
		status_word[st_in_full]                         = in_full;
		status_word[st_out_empty]                       = out_empty;
		status_word[st_out_almost_full]                 = out_almost_full;
		status_word[st_overflow]                        = overflow;
		status_word[st_out_count_hi:st_out_count_lo]    = out_count;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_ack   <= 1'b0;
			opcode   <= op_pass;
			key      <= '0;
			overflow <= 1'b0;
		end else begin
			wb_ack <= req;	// Single-cycle registered ack
			if (wr_req) begin
				case (wb_adr)
				addr_data: if (in_full) overflow <= 1'b1;	// Dropped push
				addr_ctrl: begin
					opcode <= op_e'(wb_wdata[1:0]);
					if (wb_wdata[ctrl_clr_ovf])
						overflow <= 1'b0;
				end
				addr_key:  key <= wb_wdata;
				default:   ;	// Status is read-only
				endcase
			end
		end
	end

	// Read data is captured with the ack edge
	always_ff @(posedge clk) begin
		if (rd_req) begin
			case (wb_adr)
			addr_data:   wb_rdata <= out_rdata;	// Zero when output FIFO empty
			addr_ctrl:   wb_rdata <= {{(data_w-2){1'b0}}, opcode};
			addr_key:    wb_rdata <= key;
			addr_status: wb_rdata <= status_word;
			default:     wb_rdata <= '0;
			endcase
		end
	end

endmodule : wb_regs

`default_nettype wire

//--- source/word_engine.sv
`timescale 1ns/1ps
`default_nettype none

module word_engine import mailbox_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  op_e               opcode,	// Sampled at pop
	input  logic [data_w-1:0] key,
	input  logic [data_w-1:0] in_rdata,	// Combinational head of input FIFO
	input  logic              in_empty,
	output logic              in_rd,
	output logic [data_w-1:0] out_wdata,	// Result register
	input  logic              out_full,
	output logic              out_wr
);

	eng_state_e state;
	eng_state_e state_nxt;

	function automatic logic [data_w-1:0] transform(
		input op_e               op,
		input logic [data_w-1:0] w,
		input logic [data_w-1:0] k
	);
		case (op)
		op_pass:   return w;
		op_invert: return ~w;
		op_swap:   return {w[7:0], w[15:8], w[23:16], w[31:24]};	// Byte reverse
		op_add:    return w + k;	// Wraps modulo 2^32
		default:   return w;
		endcase
	endfunction

	// Pop only with room downstream so the push never stalls
	assign in_rd  = (state == st_idle) && !in_empty && !out_full;
	assign out_wr = (state == st_push);	// One cycle per popped word

	always_comb begin
		state_nxt = state;
		case (state)
		st_idle: if (in_rd) state_nxt = st_push;
		st_push: state_nxt = st_idle;
		default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk) begin
		if (in_rd)
			out_wdata <= transform(opcode, in_rdata, key);	// Latch result at pop
	end

endmodule : word_engine

`default_nettype wire

//--- source/mailbox_top.sv
`timescale 1ns/1ps
`default_nettype none

module mailbox_top import mailbox_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  logic [addr_w-1:0] wb_adr,
	input  logic [data_w-1:0] wb_wdata,
	output logic [data_w-1:0] wb_rdata,
	output logic              wb_ack
);

	logic                   in_wr;	// Host push
	logic [data_w-1:0]      in_wdata;
	logic                   in_rd;	// Engine pop
	logic [data_w-1:0]      in_rdata;
	logic                   in_empty;
	logic                   in_full;
	logic                   out_wr;	// Engine push
	logic [data_w-1:0]      out_wdata;
	logic                   out_rd;	// Host pop
	logic [data_w-1:0]      out_rdata;
	logic                   out_empty;
	logic                   out_full;
	logic                   out_almost_full;
	logic [out_depth_log:0] out_count;
	op_e                    opcode;
	logic [data_w-1:0]      key;

	wb_regs regs_i (.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata,
		.wb_ack, .in_wr, .in_wdata, .in_empty, .in_full, .out_rd, .out_rdata, .out_empty,
		.out_almost_full, .out_count, .opcode, .key);

	fifo #(.BUF_WIDTH(in_depth_log), .DATA_WIDTH(data_w)) in_fifo_i (.clk, .rst,
		.buf_in(in_wdata), .wr_en(in_wr), .rd_en(in_rd), .buf_out(in_rdata),
		.buf_empty(in_empty), .buf_full(in_full), .buf_almost_full(), .fifo_counter());

	fifo #(.BUF_WIDTH(out_depth_log), .DATA_WIDTH(data_w)) out_fifo_i (.clk, .rst,
		.buf_in(out_wdata), .wr_en(out_wr), .rd_en(out_rd), .buf_out(out_rdata),
		.buf_empty(out_empty), .buf_full(out_full), .buf_almost_full(out_almost_full),
		.fifo_counter(out_count));

	word_engine engine_i (.clk, .rst, .opcode, .key, .in_rdata, .in_empty, .in_rd,
		.out_wdata, .out_full, .out_wr);

endmodule : mailbox_top

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);

	localparam int rst_cycles = 4;	// Rising edges seen with reset high

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		repeat (rst_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;	// Release away from the active edge
	end

	always #50 clk = ~clk;	// 100 ns period

endmodule : tb_clock

`default_nettype wire

//--- bench/mailbox_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mailbox_checker import mailbox_pkg::*; (
	input  logic              clk,
	input  logic              wb_ack,
	input  logic              wb_we,
	input  logic [data_w-1:0] wb_rdata
);

	int                exp_test[$];	// Test number per pending read
	logic [data_w-1:0] exp_data[$];	// Expected wb_rdata per pending read
	int                checks;	// Reads compared in the current test
	int                errors;	// Mismatches in the current test
	int                tests_passed;
	int                tests_failed;

	initial begin
		checks       = 0;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
	end

	task automatic expect_read(input int test, input logic [data_w-1:0] value);
		exp_test.push_back(test);
		exp_data.push_back(value);
	endtask

	// Falling edge is half a cycle after the ack edge, data is stable
	always @(negedge clk) begin
		if (wb_ack && !wb_we && exp_data.size() > 0) begin
			checks++;
			if (wb_rdata !== exp_data[0]) begin
				errors++;
				$display("Fail at %0t ns: test %0d wb_rdata expected %08h, got %08h",
					$time, exp_test[0], exp_data[0], wb_rdata);
			end
			exp_test.delete(0);
			exp_data.delete(0);
		end
	end

	task automatic end_test(input int test);
		if (errors == 0) begin
			tests_passed++;
			$display("Test %0d passed, %0d reads checked", test, checks);
		end else begin
			tests_failed++;
			$display("Test %0d failed, %0d of %0d reads wrong", test, errors, checks);
		end
		checks = 0;
		errors = 0;
	endtask

	task automatic abort_test(input int test);
		tests_failed++;
		$display("Test %0d stopped before its end", test);
	endtask

endmodule : mailbox_checker

`default_nettype wire

//--- bench/mailbox_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mailbox_assert (
	input  logic clk,
	input  logic rst,
	input  logic wb_ack,
	input  logic in_rd,	// Engine pop
	input  logic in_empty,
	input  logic out_wr,	// Engine push
	input  logic out_full
);

	ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for two cycles");

	push_room: assert property (@(posedge clk) disable iff (rst) out_wr |-> !out_full)
		else $error("out_wr while the output FIFO is full");

	pop_data: assert property (@(posedge clk) disable iff (rst) in_rd |-> !in_empty)
		else $error("in_rd while the input FIFO is empty");

	ack_in_reset: assert property (@(posedge clk) rst |-> !wb_ack)	// Quiet bus in reset
		else $error("wb_ack high during reset");

endmodule : mailbox_assert

bind mailbox_top mailbox_assert assert_i (.clk, .rst, .wb_ack, .in_rd, .in_empty, .out_wr,
	.out_full);

`default_nettype wire

//--- bench/mailbox_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mailbox_tb import mailbox_pkg::*; ();

	localparam int ack_limit  = 20;	// Cycles allowed for one ack
	localparam int poll_limit = 200;	// Status reads allowed per poll
	localparam int rst_limit  = 20;	// Cycles allowed for reset release

	logic              clk;
	logic              rst;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_we;
	logic [addr_w-1:0] wb_adr;
	logic [data_w-1:0] wb_wdata;
	logic [data_w-1:0] wb_rdata;
	logic              wb_ack;
	logic              stopped;	// Timeout or bad record ends the run

	tb_clock clock_i (.clk, .rst);

	mailbox_top dut_i (.clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata, .wb_rdata,
		.wb_ack);

	mailbox_checker checker_i (.clk, .wb_ack, .wb_we, .wb_rdata);

	// One classic cycle, idle cycle first so stb drops between transfers
	task automatic bus_transfer(input logic we, input logic [addr_w-1:0] adr,
		input logic [data_w-1:0] data, input logic check, input int test,
		input logic [data_w-1:0] expv, output logic [data_w-1:0] rdata, output logic ok);
		int n;
		n = 0;
		@(negedge clk);
		if (check)
			checker_i.expect_read(test, expv);	// Ack is low here, no race with the checker
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_wdata = data;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < ack_limit);
		ok     = wb_ack;
		rdata  = wb_rdata;
		wb_cyc = 1'b0;	// we stays put until the next transfer
		wb_stb = 1'b0;
		if (!ok)
			$display("Timeout at %0t ns: no wb_ack for address %0d", $time, adr);
	endtask

	// Read status until the output level field equals level
	task automatic poll_out_count(input int level, output logic ok);
		logic [data_w-1:0] st;
		logic              bus_ok;
		int                n;
		n      = 0;
		ok     = 1'b0;
		bus_ok = 1'b1;
		while (!ok && bus_ok && n < poll_limit) begin
			bus_transfer(1'b0, addr_status, '0, 1'b0, 0, '0, st, bus_ok);
			ok = bus_ok && (int'(st[st_out_count_hi:st_out_count_lo]) == level);
			n++;
		end
		if (!ok && bus_ok)
			$display("Timeout at %0t ns: out_count never reached %0d", $time, level);
	endtask

	initial begin
		int                fd;
		int                n;
		int                fields;
		int                test;
		string             line;
		logic [7:0]        cmd;
		logic [addr_w-1:0] adr;
		logic [data_w-1:0] data;
		logic [data_w-1:0] expv;
		logic [data_w-1:0] rdata;
		logic              ok;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_wdata = '0;
		stopped  = 1'b0;
		test     = 0;
		n        = 0;
		while (rst !== 1'b0 && n < rst_limit) begin	// Unknown at time zero counts as reset
			@(negedge clk);
			n++;
		end
		if (rst !== 1'b0) begin
			$display("Reset was never released");
			stopped = 1'b1;
		end
		fd = $fopen("bench/mailbox_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/mailbox_stimulus.txt");
			stopped = 1'b1;
		end
		while (!stopped && !$feof(fd)) begin
			line = "";
			n    = $fgets(line, fd);
			if (n > 1 && line[0] != "#") begin	// Skip blank and comment lines
				fields = $sscanf(line, "%s %d %h %h %h", cmd, test, adr, data, expv);
				ok     = 1'b1;
				if (fields != 5) begin
					$display("Malformed stimulus record: %s", line);
					ok = 1'b0;
				end else begin
					case (cmd)
					"W": bus_transfer(1'b1, adr, data, 1'b0, test, '0, rdata, ok);
					"R": bus_transfer(1'b0, adr, '0, 1'b1, test, expv, rdata, ok);
					"P": poll_out_count(int'(data), ok);
					"E": begin
						@(negedge clk);	// Let the last compare land first
						checker_i.end_test(test);
					end
					default: begin
						$display("Unknown command in stimulus record: %s", line);
						ok = 1'b0;
					end
					endcase
				end
				stopped = !ok;
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (stopped)
			checker_i.abort_test(test);
		$display("Tests passed: %0d, tests failed: %0d", checker_i.tests_passed,
			checker_i.tests_failed);
		if (!stopped && checker_i.tests_failed == 0 && checker_i.tests_passed > 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule : mailbox_tb

`default_nettype wire

//--- bench/mailbox_stimulus.txt
# cmd test adr data expect; W write, R read and compare, P poll until out_count = data, E end
# adr 0 data, 1 ctrl, 2 key, 3 status; data and expect in hex
R 1 3 00000000 00000005
R 1 1 00000000 00000000
R 1 2 00000000 00000000
E 1 0 00000000 00000000
W 2 0 00000001 00000000
W 2 0 deadbeef 00000000
W 2 0 cafef00d 00000000
W 2 0 01234567 00000000
W 2 0 ffffffff 00000000
P 2 3 00000004 00000000
R 2 0 00000000 00000001
R 2 0 00000000 deadbeef
R 2 0 00000000 cafef00d
R 2 0 00000000 01234567
R 2 0 00000000 ffffffff
E 2 0 00000000 00000000
W 3 1 00000001 00000000
W 3 0 12345678 00000000
W 3 0 a5a5f00f 00000000
P 3 3 00000002 00000000
R 3 0 00000000 edcba987
R 3 0 00000000 5a5a0ff0
W 3 1 00000002 00000000
W 3 0 12345678 00000000
P 3 3 00000001 00000000
R 3 0 00000000 78563412
W 3 2 80000001 00000000
W 3 1 00000003 00000000
W 3 0 a5a5f00f 00000000
P 3 3 00000001 00000000
R 3 0 00000000 25a5f010
W 3 1 00000000 00000000
E 3 0 00000000 00000000
W 4 0 10000001 00000000
W 4 0 10000002 00000000
W 4 0 10000003 00000000
W 4 0 10000004 00000000
W 4 0 10000005 00000000
W 4 0 10000006 00000000
W 4 0 10000007 00000000
W 4 0 10000008 00000000
W 4 0 10000009 00000000
W 4 0 1000000a 00000000
W 4 0 1000000b 00000000
W 4 0 1000000c 00000000
P 4 3 00000004 00000000
R 4 3 00000000 0000040a
W 4 0 1000000d 00000000
R 4 3 00000000 0000041a
R 4 0 00000000 10000001
R 4 0 00000000 10000002
R 4 0 00000000 10000003
R 4 0 00000000 10000004
R 4 0 00000000 10000005
R 4 0 00000000 10000006
R 4 0 00000000 10000007
R 4 0 00000000 10000008
R 4 0 00000000 10000009
R 4 0 00000000 1000000a
R 4 0 00000000 1000000b
R 4 0 00000000 1000000c
W 4 1 80000000 00000000
R 4 3 00000000 00000005
E 4 0 00000000 00000000
R 5 3 00000000 00000005
R 5 0 00000000 00000000
R 5 3 00000000 00000005
E 5 0 00000000 00000000

//--- mailbox.f
source/mailbox_pkg.sv
source/fifo.sv
source/wb_regs.sv
source/word_engine.sv
source/mailbox_top.sv
bench/tb_clock.sv
bench/mailbox_checker.sv
bench/mailbox_assert.sv
bench/mailbox_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the mailbox testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mailbox_tb -f mailbox.f -o mailbox_sim
out=$(./obj_dir/mailbox_sim) || true
echo "$out"
if echo "$out" | grep -qx "Result: PASSED"; then
	exit 0
else
	exit 1
fi
